/* logic/fp_add_pkg.sv */
/* binary32 only, round to nearest even is the single rounding mode
   every NaN result leaves as the canonical quiet NaN */
`default_nettype none

package fp_add_pkg;

    // binary32 field widths
    localparam int WORD_W = 32;
    localparam int EXP_W  = 8;
    localparam int FRAC_W = 23;
    // hidden bit, fraction, then guard, round and sticky
    localparam int SIG_W  = 27;
    // holds any shift from 0 up to SIG_W
    localparam int SHIFT_W = $clog2(SIG_W + 1);

    localparam logic [EXP_W-1:0]  EXP_ALL_ONES = 8'hFF;
    // sign 0, exponent all ones, fraction all ones
    localparam logic [WORD_W-1:0] QNAN_WORD    = 32'h7FFF_FFFF;

    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } fp_fields_t;

    // raw view for magnitude compares, field view for decode and pack
    typedef union packed {
        logic [WORD_W-1:0] raw;
        fp_fields_t        f;
    } fp_word_u;

    // special case tag, travels with the operation down the pipe
    typedef enum logic [2:0] {
        SPC_NONE    = 3'd0,
        SPC_ZERO_OP = 3'd1,
        SPC_INF     = 3'd2,
        SPC_NAN     = 3'd3,
        SPC_ZERO    = 3'd4
    } special_e;

    // exception code, 2 and 5 stay unused here
    typedef enum logic [2:0] {
        ERR_NONE      = 3'd0,
        ERR_INVALID   = 3'd1,
        ERR_OVERFLOW  = 3'd3,
        ERR_UNDERFLOW = 3'd4
    } fp_err_e;

endpackage

`default_nettype wire

/* logic/error_check.sv */
/* combinational pack of the final word, the code depends on that word alone
   no inexact and no divide-by-zero code */
`default_nettype none
`timescale 1ns/1ns

module error_check
    import fp_add_pkg::*;
(
    input  wire                sign_i,
    input  wire [EXP_W-1:0]    exp_i,
    input  wire [SIG_W-1:0]    sig_untrunc_i,
    input  wire special_e      special_i,
    input  wire fp_word_u      nz_op_i,
    output fp_word_u           fp_o,
    output fp_err_e            err_o
);

    logic exp_ones;
    logic exp_zero;
    logic frac_zero;

    always_comb begin
        // computed fields by default
        fp_o.f.sign = sign_i;
        fp_o.f.exp  = exp_i;
        // drop hidden bit on top and grs bits below
        fp_o.f.frac = sig_untrunc_i[SIG_W-2:3];

        case (special_i)
            SPC_ZERO_OP: begin
                // other operand passes whole, sign included
                fp_o = nz_op_i;
            end
            SPC_INF: begin
                fp_o.f.exp  = EXP_ALL_ONES;
                fp_o.f.frac = '0;
            end
            SPC_NAN: begin
                fp_o.raw = QNAN_WORD;
            end
            SPC_ZERO: begin
                // exact zero is always +0
                fp_o.raw = '0;
            end
            default: begin
                // computed fields stand
            end
        endcase
    end

    // classify the packed word
    assign exp_ones  = (fp_o.f.exp == EXP_ALL_ONES);
    assign exp_zero  = (fp_o.f.exp == '0);
    assign frac_zero = (fp_o.f.frac == '0);

    always_comb begin
        if (exp_ones && frac_zero) begin
            err_o = ERR_OVERFLOW;
        end else if (exp_ones) begin
            err_o = ERR_INVALID;
        end else if (exp_zero && !frac_zero) begin
            // subnormal result
            err_o = ERR_UNDERFLOW;
        end else begin
            err_o = ERR_NONE;
        end
    end

endmodule

`default_nettype wire

/* logic/fp_operand_decode.sv */
/* first pipe stage, registers on the edge that samples valid_i
   nz_op_o only means something when the tag is SPC_ZERO_OP */
`default_nettype none
`timescale 1ns/1ns

module fp_operand_decode
    import fp_add_pkg::*;
(
    input  wire                clk_i,
    input  wire                reset_i,
    input  wire                valid_i,
    input  wire fp_word_u      op_a_i,
    input  wire fp_word_u      op_b_i,
    input  wire                sub_i,
    output logic               d_valid_o,
    output logic               d_sign_o,
    output logic               d_eff_sub_o,
    output logic [EXP_W-1:0]   d_exp_o,
    output logic [EXP_W-1:0]   d_exp_diff_o,
    output logic [SIG_W-1:0]   d_sig_big_o,
    output logic [SIG_W-1:0]   d_sig_small_o,
    output special_e           d_special_o,
    output fp_word_u           d_nz_op_o
);

    fp_word_u         b_eff;
    fp_word_u         big;
    fp_word_u         small_op;
    logic             swap;
    logic             eff_sub;
    logic [EXP_W-1:0] big_exp;
    logic [EXP_W-1:0] small_exp;
    logic             big_nan;
    logic             small_nan;
    logic             big_inf;
    logic             small_inf;
    logic             big_zero;
    logic             small_zero;
    special_e         special;

    // a - b handled as a + (-b)
    always_comb begin
        b_eff        = op_b_i;
        b_eff.f.sign = op_b_i.f.sign ^ sub_i;
    end

    // magnitude order straight from the raw bits, sign dropped
    assign swap     = b_eff.raw[WORD_W-2:0] > op_a_i.raw[WORD_W-2:0];
    assign big      = swap ? b_eff : op_a_i;
    assign small_op = swap ? op_a_i : b_eff;

    assign eff_sub = big.f.sign ^ small_op.f.sign;

    // subnormals scale like exponent 1
    assign big_exp   = (big.f.exp == '0) ? EXP_W'(1) : big.f.exp;
    assign small_exp = (small_op.f.exp == '0) ? EXP_W'(1) : small_op.f.exp;

    // operand classes
    assign big_nan    = (big.f.exp == EXP_ALL_ONES) && (big.f.frac != '0);
    assign small_nan  = (small_op.f.exp == EXP_ALL_ONES) && (small_op.f.frac != '0);
    assign big_inf    = (big.f.exp == EXP_ALL_ONES) && (big.f.frac == '0);
    assign small_inf  = (small_op.f.exp == EXP_ALL_ONES) && (small_op.f.frac == '0);
    assign big_zero   = (big.f.exp == '0) && (big.f.frac == '0);
    assign small_zero = (small_op.f.exp == '0) && (small_op.f.frac == '0);

    always_comb begin
        if (big_nan || small_nan || (big_inf && small_inf && eff_sub)) begin
            special = SPC_NAN;
        end else if (big_inf) begin
            // any infinity sorts to the big slot
            special = SPC_INF;
        end else if (big_zero) begin
            // big zero means both are zero
            special = SPC_ZERO;
        end else if (small_zero) begin
            special = SPC_ZERO_OP;
        end else begin
            special = SPC_NONE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            d_valid_o <= 1'b0;
        end else begin
            d_valid_o <= valid_i;
        end
    end

    // payload follows each strobe
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            d_sign_o      <= big.f.sign;
            d_eff_sub_o   <= eff_sub;
            d_exp_o       <= big_exp;
            d_exp_diff_o  <= big_exp - small_exp;
            // hidden bit is 0 for subnormals, grs bits start clear
            d_sig_big_o   <= {big.f.exp != '0, big.f.frac, 3'b000};
            d_sig_small_o <= {small_op.f.exp != '0, small_op.f.frac, 3'b000};
            d_special_o   <= special;
            d_nz_op_o     <= big;
        end
    end

    // registered pair stays ordered by magnitude
    a_big_first: assert property (@(posedge clk_i) disable iff (reset_i)
        d_valid_o |-> (d_exp_diff_o != '0) || (d_sig_big_o >= d_sig_small_o));

endmodule

`default_nettype wire

/* logic/fp_align_add.sv */
/* second pipe stage, one edge after decode
   relies on decode putting the larger magnitude in the big slot */
`default_nettype none
`timescale 1ns/1ns

module fp_align_add
    import fp_add_pkg::*;
(
    input  wire                clk_i,
    input  wire                reset_i,
    input  wire                d_valid_i,
    input  wire                d_sign_i,
    input  wire                d_eff_sub_i,
    input  wire [EXP_W-1:0]    d_exp_i,
    input  wire [EXP_W-1:0]    d_exp_diff_i,
    input  wire [SIG_W-1:0]    d_sig_big_i,
    input  wire [SIG_W-1:0]    d_sig_small_i,
    input  wire special_e      d_special_i,
    input  wire fp_word_u      d_nz_op_i,
    output logic               x_valid_o,
    output logic               x_sign_o,
    output logic [EXP_W-1:0]   x_exp_o,
    output logic [SIG_W:0]     x_sum_o,
    output special_e           x_special_o,
    output fp_word_u           x_nz_op_o
);

    logic [SHIFT_W-1:0] shamt;
    logic [SIG_W-1:0]   shifted;
    logic [SIG_W-1:0]   lost_mask;
    logic               sticky;
    logic [SIG_W-1:0]   aligned;
    logic [SIG_W:0]     sum;

    // shift saturates, a wide gap pushes the whole significand into sticky
    assign shamt = (d_exp_diff_i >= EXP_W'(SIG_W)) ? SHIFT_W'(SIG_W)
                                                   : d_exp_diff_i[SHIFT_W-1:0];

    assign shifted = d_sig_small_i >> shamt;

    // ones on every bit position that falls off the right end
    assign lost_mask = ~({SIG_W{1'b1}} << shamt);
    assign sticky    = |(d_sig_small_i & lost_mask);

    // lsb of the aligned value is the sticky position
    assign aligned = {shifted[SIG_W-1:1], shifted[0] | sticky};

    // one extra bit on top for the carry
    always_comb begin
        if (d_eff_sub_i) begin
            sum = {1'b0, d_sig_big_i} - {1'b0, aligned};
        end else begin
            sum = {1'b0, d_sig_big_i} + {1'b0, aligned};
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            x_valid_o <= 1'b0;
        end else begin
            x_valid_o <= d_valid_i;
        end
    end

    // sign, exponent, tag and the passing word ride along untouched
    always_ff @(posedge clk_i) begin
        if (d_valid_i) begin
            x_sign_o    <= d_sign_i;
            x_exp_o     <= d_exp_i;
            x_sum_o     <= sum;
            x_special_o <= d_special_i;
            x_nz_op_o   <= d_nz_op_i;
        end
    end

    // a borrow here would mean decode swapped the wrong way
    sub_not_negative: assert property (@(posedge clk_i) disable iff (reset_i)
        (d_valid_i && d_eff_sub_i) |-> !sum[SIG_W]);

endmodule

`default_nettype wire

/* logic/fp_result_stage.sv */
/* last pipe stage, normalize, round to nearest even, pack
   result_o and err_o hold their value while valid_o is low */
`default_nettype none
`timescale 1ns/1ns

module fp_result_stage
    import fp_add_pkg::*;
(
    input  wire                clk_i,
    input  wire                reset_i,
    input  wire                x_valid_i,
    input  wire                x_sign_i,
    input  wire [EXP_W-1:0]    x_exp_i,
    input  wire [SIG_W:0]      x_sum_i,
    input  wire special_e      x_special_i,
    input  wire fp_word_u      x_nz_op_i,
    output logic               valid_o,
    output fp_word_u           result_o,
    output fp_err_e            err_o
);

    logic [SHIFT_W-1:0] lzc;
    logic [EXP_W:0]     exp_limit;
    logic [SHIFT_W-1:0] lshift;
    logic [SIG_W-1:0]   norm;
    logic [EXP_W:0]     norm_exp;
    logic               round_up;
    logic [FRAC_W+1:0]  mant;
    logic [FRAC_W:0]    rnd_sig;
    logic [EXP_W:0]     rnd_exp;
    special_e           special;
    fp_word_u           fp_word;
    fp_err_e            err;

    // highest set bit wins, all zero gives SIG_W
    function automatic logic [SHIFT_W-1:0] lead_zeros(input logic [SIG_W-1:0] v);
        logic [SHIFT_W-1:0] n;
        n = SHIFT_W'(SIG_W);
        for (int i = 0; i < SIG_W; i++) begin
            if (v[i]) begin
                n = SHIFT_W'(SIG_W - 1 - i);
            end
        end
        return n;
    endfunction

    assign lzc = lead_zeros(x_sum_i[SIG_W-1:0]);

    // left shift may not take the exponent under 1
    assign exp_limit = {1'b0, x_exp_i} - 1'b1;
    assign lshift    = (lzc > exp_limit) ? exp_limit[SHIFT_W-1:0] : lzc;

    always_comb begin
        if (x_sum_i[SIG_W]) begin
            // carry out, one place right, dropped bit folds into sticky
            norm     = {x_sum_i[SIG_W:2], x_sum_i[1] | x_sum_i[0]};
            norm_exp = {1'b0, x_exp_i} + 1'b1;
        end else begin
            norm = x_sum_i[SIG_W-1:0] << lshift;
            // hidden bit still clear means a subnormal
            norm_exp = norm[SIG_W-1] ? ({1'b0, x_exp_i} - lshift) : '0;
        end
    end

    // guard and then round or sticky or odd lsb
    assign round_up = norm[2] && (norm[1] || norm[0] || norm[3]);
    assign mant     = {1'b0, norm[SIG_W-1:3]} + round_up;

    always_comb begin
        if (mant[FRAC_W+1]) begin
            // 1.11..1 rounded up to 10.0, renormalize
            rnd_sig = mant[FRAC_W+1:1];
            rnd_exp = norm_exp + 1'b1;
        end else begin
            rnd_sig = mant[FRAC_W:0];
            // largest subnormal can round into the smallest normal
            rnd_exp = ((norm_exp == '0) && mant[FRAC_W]) ? (EXP_W+1)'(1) : norm_exp;
        end
    end

    // computed path can still cancel to zero or overflow
    always_comb begin
        special = x_special_i;
        if (x_special_i == SPC_NONE) begin
            if (x_sum_i == '0) begin
                special = SPC_ZERO;
            end else if (rnd_exp >= {1'b0, EXP_ALL_ONES}) begin
                special = SPC_INF;
            end
        end
    end

    // grs bits are spent after rounding
    error_check u_error_check (
        .sign_i        (x_sign_i),
        .exp_i         (rnd_exp[EXP_W-1:0]),
        .sig_untrunc_i ({rnd_sig, 3'b000}),
        .special_i     (special),
        .nz_op_i       (x_nz_op_i),
        .fp_o          (fp_word),
        .err_o         (err)
    );

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= x_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (x_valid_i) begin
            result_o <= fp_word;
            err_o    <= err;
        end
    end

    // only the four defined codes ever leave the pipe
    err_code_legal: assert property (@(posedge clk_i) disable iff (reset_i)
        valid_o |-> (err_o inside {ERR_NONE, ERR_INVALID, ERR_OVERFLOW, ERR_UNDERFLOW}));

endmodule

`default_nettype wire

/* logic/fp_add_top.sv */
/* fixed latency of 3 edges, one operation per strobe, no back-pressure
   results leave in issue order */
`default_nettype none
`timescale 1ns/1ns

module fp_add_top
    import fp_add_pkg::*;
(
    input  wire                clk_i,
    input  wire                reset_i,
    input  wire                valid_i,
    input  wire fp_word_u      op_a_i,
    input  wire fp_word_u      op_b_i,
    input  wire                sub_i,
    output logic               valid_o,
    output fp_word_u           result_o,
    output fp_err_e            err_o
);

    // decode to execute
    logic             d_valid;
    logic             d_sign;
    logic             d_eff_sub;
    logic [EXP_W-1:0] d_exp;
    logic [EXP_W-1:0] d_exp_diff;
    logic [SIG_W-1:0] d_sig_big;
    logic [SIG_W-1:0] d_sig_small;
    special_e         d_special;
    fp_word_u         d_nz_op;

    // execute to result
    logic             x_valid;
    logic             x_sign;
    logic [EXP_W-1:0] x_exp;
    logic [SIG_W:0]   x_sum;
    special_e         x_special;
    fp_word_u         x_nz_op;

    fp_operand_decode u_decode (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .valid_i       (valid_i),
        .op_a_i        (op_a_i),
        .op_b_i        (op_b_i),
        .sub_i         (sub_i),
        .d_valid_o     (d_valid),
        .d_sign_o      (d_sign),
        .d_eff_sub_o   (d_eff_sub),
        .d_exp_o       (d_exp),
        .d_exp_diff_o  (d_exp_diff),
        .d_sig_big_o   (d_sig_big),
        .d_sig_small_o (d_sig_small),
        .d_special_o   (d_special),
        .d_nz_op_o     (d_nz_op)
    );

    fp_align_add u_execute (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .d_valid_i     (d_valid),
        .d_sign_i      (d_sign),
        .d_eff_sub_i   (d_eff_sub),
        .d_exp_i       (d_exp),
        .d_exp_diff_i  (d_exp_diff),
        .d_sig_big_i   (d_sig_big),
        .d_sig_small_i (d_sig_small),
        .d_special_i   (d_special),
        .d_nz_op_i     (d_nz_op),
        .x_valid_o     (x_valid),
        .x_sign_o      (x_sign),
        .x_exp_o       (x_exp),
        .x_sum_o       (x_sum),
        .x_special_o   (x_special),
        .x_nz_op_o     (x_nz_op)
    );

    fp_result_stage u_result (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .x_valid_i   (x_valid),
        .x_sign_i    (x_sign),
        .x_exp_i     (x_exp),
        .x_sum_i     (x_sum),
        .x_special_i (x_special),
        .x_nz_op_i   (x_nz_op),
        .valid_o     (valid_o),
        .result_o    (result_o),
        .err_o       (err_o)
    );

endmodule

`default_nettype wire

/* verification/tb_fp_add.sv */
/* vector table, then random x + 0 and x - x identities with gaps
   every output must arrive exactly 3 edges after its strobe, in order */
`default_nettype none
`timescale 1ns/1ns

module tb_fp_add
    import fp_add_pkg::*;
();

    localparam int CLK_HALF     = 10;
    localparam int RESET_CYCLES = 8;
    localparam int LATENCY      = 3;
    localparam int NUM_VEC      = 16;
    localparam int NUM_RAND_X   = 24;
    // each random x gives two operations
    localparam int RAND_OPS     = 2 * NUM_RAND_X;
    localparam int WATCHDOG_NS  = (NUM_VEC + RAND_OPS + 20) * LATENCY * 2 * CLK_HALF;
    localparam logic [31:0] LFSR_SEED = 32'h922c_bcd1;
    // right shifting galois form, taps 32 30 26 25
    localparam logic [31:0] LFSR_TAPS = 32'hA300_0000;

    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        logic        sub;
        logic [31:0] word;
        fp_err_e     err;
    } vec_t;

    // a, b, subtract, expected word, expected code
    localparam vec_t VECS [NUM_VEC] = '{
        // 1.0 + 2.0
        '{32'h3F80_0000, 32'h4000_0000, 1'b0, 32'h4040_0000, ERR_NONE},
        // 1.5 - 0.5
        '{32'h3FC0_0000, 32'h3F00_0000, 1'b1, 32'h3F80_0000, ERR_NONE},
        // exact half ulp, even lsb stays
        '{32'h3F80_0000, 32'h3380_0000, 1'b0, 32'h3F80_0000, ERR_NONE},
        // exact half ulp, odd lsb rounds up
        '{32'h3F80_0001, 32'h3380_0000, 1'b0, 32'h3F80_0002, ERR_NONE},
        // just above half ulp, sticky tips it up
        '{32'h3F80_0000, 32'h3380_0001, 1'b0, 32'h3F80_0001, ERR_NONE},
        // gap of 25, sticky pulls the result below the tie
        '{32'h3F80_0000, 32'h3300_0001, 1'b1, 32'h3F7F_FFFF, ERR_NONE},
        // 1.0 - (-1.0)
        '{32'h3F80_0000, 32'hBF80_0000, 1'b1, 32'h4000_0000, ERR_NONE},
        // inf - inf
        '{32'h7F80_0000, 32'h7F80_0000, 1'b1, QNAN_WORD, ERR_INVALID},
        // quiet nan operand
        '{32'h7FC0_0000, 32'h3F80_0000, 1'b0, QNAN_WORD, ERR_INVALID},
        // inf + 1.0
        '{32'h7F80_0000, 32'h3F80_0000, 1'b0, 32'h7F80_0000, ERR_OVERFLOW},
        // 1.0 + -inf keeps the sign
        '{32'h3F80_0000, 32'hFF80_0000, 1'b0, 32'hFF80_0000, ERR_OVERFLOW},
        // max normal twice
        '{32'h7F7F_FFFF, 32'h7F7F_FFFF, 1'b0, 32'h7F80_0000, ERR_OVERFLOW},
        // 0 + pi
        '{32'h0000_0000, 32'h4049_0FDB, 1'b0, 32'h4049_0FDB, ERR_NONE},
        // +0 + -0
        '{32'h0000_0000, 32'h8000_0000, 1'b0, 32'h0000_0000, ERR_NONE},
        // smallest normal minus half of it
        '{32'h0080_0000, 32'h0040_0000, 1'b1, 32'h0040_0000, ERR_UNDERFLOW},
        // exact cancel
        '{32'h3F80_0000, 32'h3F80_0000, 1'b1, 32'h0000_0000, ERR_NONE}
    };

    logic        clk;
    logic        reset;
    logic        valid_in;
    fp_word_u    op_a;
    fp_word_u    op_b;
    logic        sub;
    logic        valid_out;
    fp_word_u    result;
    fp_err_e     err;

    logic [31:0] lfsr;
    int          edge_count;
    logic        pending;

    // scoreboard, one entry per strobe
    fp_word_u    exp_word_q[$];
    fp_err_e     exp_err_q[$];
    int          exp_edge_q[$];

    fp_add_top uut (
        .clk_i    (clk),
        .reset_i  (reset),
        .valid_i  (valid_in),
        .op_a_i   (op_a),
        .op_b_i   (op_b),
        .sub_i    (sub),
        .valid_o  (valid_out),
        .result_o (result),
        .err_o    (err)
    );

    initial clk = 1'b0;
    always #(CLK_HALF) clk = ~clk;

    // rising edges seen so far
    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input fp_word_u act, input fp_word_u exp);
        if (act.raw !== exp.raw) begin
            abort_run($sformatf("Mismatch result_o: got %h expected %h", act.raw, exp.raw));
        end
    endtask

    task automatic check_err(input fp_err_e act, input fp_err_e exp);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch err_o: got %h expected %h", act, exp));
        end
    endtask

    task automatic check_valid(input logic act, input logic exp);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch valid_o: got %h expected %h at edge %0d",
                                act, exp, edge_count));
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // random finite operand, every 8th one forced subnormal
    task automatic draw_operand(input int idx, output fp_word_u x);
        logic [31:0] bits;
        take_bits(32, bits);
        x.raw = bits;
        if (idx % 8 == 0) begin
            x.f.exp = '0;
        end
        // redraw the exponent until no nan or inf
        while (x.f.exp == EXP_ALL_ONES) begin
            take_bits(8, bits);
            x.f.exp = bits[7:0];
        end
    endtask

    // drive one strobe and queue what should come back
    task automatic issue(input fp_word_u a, input fp_word_u b, input logic s,
                         input fp_word_u exp_word, input fp_err_e exp_err);
        @(negedge clk);
        valid_in = 1'b1;
        op_a     = a;
        op_b     = b;
        sub      = s;
        exp_word_q.push_back(exp_word);
        exp_err_q.push_back(exp_err);
        // sampled on the next edge, visible after two more
        exp_edge_q.push_back(edge_count + LATENCY);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        valid_in = 1'b0;
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (reset) begin
            check_valid(valid_out, 1'b0);
        end else begin
            pending = (exp_edge_q.size() > 0) && (exp_edge_q[0] == edge_count);
            check_valid(valid_out, pending);
            if (valid_out) begin
                check_word(result, exp_word_q.pop_front());
                check_err(err, exp_err_q.pop_front());
                void'(exp_edge_q.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("Timeout, outputs did not all arrive before the watchdog expired");
    end

    initial begin
        fp_word_u    a;
        fp_word_u    b;
        fp_word_u    x;
        fp_word_u    w;
        fp_word_u    zero_w;
        fp_err_e     e;
        logic [31:0] gap;

        reset      = 1'b1;
        valid_in   = 1'b0;
        op_a       = '0;
        op_b       = '0;
        sub        = 1'b0;
        edge_count = 0;
        lfsr       = LFSR_SEED;
        zero_w.raw = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // table, back to back
        for (int i = 0; i < NUM_VEC; i++) begin
            a.raw = VECS[i].a;
            b.raw = VECS[i].b;
            w.raw = VECS[i].word;
            issue(a, b, VECS[i].sub, w, VECS[i].err);
        end

        // random identities with 0 or 1 idle cycle between strobes
        for (int i = 0; i < NUM_RAND_X; i++) begin
            draw_operand(i, x);
            // x + 0 gives x, a zero x comes back as +0
            if ((x.f.exp == '0) && (x.f.frac == '0)) begin
                w.raw = '0;
                e     = ERR_NONE;
            end else begin
                w = x;
                e = (x.f.exp == '0) ? ERR_UNDERFLOW : ERR_NONE;
            end
            issue(x, zero_w, 1'b0, w, e);
            take_bits(1, gap);
            if (gap[0]) begin
                idle_cycle();
            end
            // x - x cancels to +0
            issue(x, x, 1'b1, zero_w, ERR_NONE);
            take_bits(1, gap);
            if (gap[0]) begin
                idle_cycle();
            end
        end
        idle_cycle();

        // drain, then a few quiet cycles for stray strobes
        while (exp_edge_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
logic/fp_add_pkg.sv
logic/error_check.sv
logic/fp_operand_decode.sv
logic/fp_align_add.sv
logic/fp_result_stage.sv
logic/fp_add_top.sv
verification/tb_fp_add.sv

/* Makefile */
# Verilator build and run for the single-precision adder testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_fp_add
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = TEST PASSED

SOURCES   = $(wildcard logic/*.sv) $(wildcard verification/*.sv)
BINARY    = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail, not the exit status of the binary
run: compile
	-./$(BINARY) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
